//--- list.f
+incdir+source
source/rv_pkg.sv
source/rv_stage_reg.sv
source/rv_fetch.sv
source/rv_decode.sv
source/rv_regfile.sv
source/rv_execute.sv
source/rv_core.sv
verif/rv_core_tb.sv

//--- source/rv_core.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_params.svh"

module rv_core
	import rv_pkg::*;
(
	input  wire                       clk,
	input  wire                       rst,
	input  wire [`RV_XLEN-1:0]        inst_i,
	output logic [`RV_XLEN-1:0]       inst_addr_o,
	output logic                      wb_en_o,
	output logic [`RV_REG_ADDR_W-1:0] wb_addr_o,
	output logic [`RV_XLEN-1:0]       wb_data_o,
	output logic                      wb_illegal_o
);

	fetch_t                    if_id;
	dec_t                      id_d;
	dec_t                      id_ex;
	wb_t                       ex_res;
	wb_t                       ex_mem;
	wb_t                       mem_wb;

	logic                      rs1_en;
	logic                      rs2_en;
	logic [`RV_REG_ADDR_W-1:0] rs1_addr;
	logic [`RV_REG_ADDR_W-1:0] rs2_addr;
	logic [`RV_XLEN-1:0]       rs1_data;
	logic [`RV_XLEN-1:0]       rs2_data;

	rv_fetch fetch_inst (
		.clk         (clk),
		.rst         (rst),
		.inst_i      (inst_i),
		.inst_addr_o (inst_addr_o),
		.fetch_o     (if_id)
	);

	rv_decode decode_inst (
		.fetch_i    (if_id),
		.rs1_en_o   (rs1_en),
		.rs2_en_o   (rs2_en),
		.rs1_addr_o (rs1_addr),
		.rs2_addr_o (rs2_addr),
		.rs1_data_i (rs1_data),
		.rs2_data_i (rs2_data),
		.ex_fwd_i   (ex_res),
		.mem_fwd_i  (ex_mem),
		.dec_o      (id_d)
	);

	rv_regfile regfile_inst (
		.clk        (clk),
		.rst        (rst),
		.rs1_addr_i (rs1_addr),
		.rs2_addr_i (rs2_addr),
		.rs1_en_i   (rs1_en),
		.rs2_en_i   (rs2_en),
		.rs1_data_o (rs1_data),
		.rs2_data_o (rs2_data),
		.wb_i       (mem_wb)
	);

	rv_stage_reg #(.payload_t(dec_t)) id_ex_reg (
		.clk (clk),
		.rst (rst),
		.d_i (id_d),
		.q_o (id_ex)
	);

	rv_execute execute_inst (
		.dec_i (id_ex),
		.res_o (ex_res)
	);

	rv_stage_reg #(.payload_t(wb_t)) ex_mem_reg (
		.clk (clk),
		.rst (rst),
		.d_i (ex_res),
		.q_o (ex_mem)
	);

	// memory stage only passes results along
	rv_stage_reg #(.payload_t(wb_t)) mem_wb_reg (
		.clk (clk),
		.rst (rst),
		.d_i (ex_mem),
		.q_o (mem_wb)
	);

	assign wb_en_o      = mem_wb.we;
	assign wb_addr_o    = mem_wb.waddr;
	assign wb_data_o    = mem_wb.wdata;
	assign wb_illegal_o = mem_wb.illegal;

endmodule

`default_nettype wire

//--- source/rv_decode.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_params.svh"

module rv_decode
	import rv_pkg::*;
(
	input  fetch_t                    fetch_i,

	output logic                      rs1_en_o,
	output logic                      rs2_en_o,
	output logic [`RV_REG_ADDR_W-1:0] rs1_addr_o,
	output logic [`RV_REG_ADDR_W-1:0] rs2_addr_o,
	input  wire [`RV_XLEN-1:0]        rs1_data_i,
	input  wire [`RV_XLEN-1:0]        rs2_data_i,

	input  wb_t                       ex_fwd_i,
	input  wb_t                       mem_fwd_i,

	output dec_t                      dec_o
);

	logic [6:0]                opcode;
	logic [`RV_REG_ADDR_W-1:0] rd;
	logic [2:0]                funct3;
	logic [`RV_REG_ADDR_W-1:0] rs1;
	logic [`RV_REG_ADDR_W-1:0] rs2;
	logic [6:0]                funct7;
	logic                      base7;
	logic                      alt7;
	logic [`RV_XLEN-1:0]       imm_i;
	logic [`RV_XLEN-1:0]       imm_u;
	logic [`RV_XLEN-1:0]       imm_sh;

	logic                      legal;
	logic                      we;
	alu_op_e                   alu_op;
	res_sel_e                  res_sel;
	logic [`RV_XLEN-1:0]       imm;

	assign opcode = fetch_i.inst[6:0];
	assign rd     = fetch_i.inst[11:7];
	assign funct3 = fetch_i.inst[14:12];
	assign rs1    = fetch_i.inst[19:15];
	assign rs2    = fetch_i.inst[24:20];
	assign funct7 = fetch_i.inst[31:25];
	assign base7  = (funct7 == `FUNCT7_BASE);
	assign alt7   = (funct7 == `FUNCT7_ALT);

	assign imm_i  = {{(`RV_XLEN-12){fetch_i.inst[31]}}, fetch_i.inst[31:20]};
	assign imm_u  = {fetch_i.inst[31:12], 12'h000};
	// shift amount sits in the rs2 field
	assign imm_sh = {{(`RV_XLEN-`RV_REG_ADDR_W){1'b0}}, rs2};

	always_comb
	begin
		alu_op     = ALU_NOP;
		res_sel    = RES_NOP;
		rs1_en_o   = 1'b0;
		rs2_en_o   = 1'b0;
		rs1_addr_o = rs1;
		rs2_addr_o = rs2;
		imm        = '0;
		legal      = 1'b0;

		case (opcode)
			`OP_LUI:
			begin
				// or with x0
				alu_op     = ALU_OR;
				res_sel    = RES_LOGIC;
				rs1_en_o   = 1'b1;
				rs1_addr_o = '0;
				imm        = imm_u;
				legal      = 1'b1;
			end

			`OP_OPI:
			begin
				rs1_en_o = 1'b1;
				imm      = imm_i;
				case (funct3)
					`FUNCT3_ADD_SUB:
					begin
						alu_op  = ALU_ADD;
						res_sel = RES_ARITH;
						legal   = 1'b1;
					end
					`FUNCT3_XOR:
					begin
						alu_op  = ALU_XOR;
						res_sel = RES_LOGIC;
						legal   = 1'b1;
					end
					`FUNCT3_OR:
					begin
						alu_op  = ALU_OR;
						res_sel = RES_LOGIC;
						legal   = 1'b1;
					end
					`FUNCT3_AND:
					begin
						alu_op  = ALU_AND;
						res_sel = RES_LOGIC;
						legal   = 1'b1;
					end
					`FUNCT3_SLL:
					begin
						alu_op  = ALU_SLL;
						res_sel = RES_SHIFT;
						imm     = imm_sh;
						legal   = base7;
					end
					`FUNCT3_SRL_SRA:
					begin
						alu_op  = alt7 ? ALU_SRA : ALU_SRL;
						res_sel = RES_SHIFT;
						imm     = imm_sh;
						legal   = base7 || alt7;
					end
					default:
					begin
						legal = 1'b0;
					end
				endcase
			end

			`OP_OP:
			begin
				rs1_en_o = 1'b1;
				rs2_en_o = 1'b1;
				case (funct3)
					`FUNCT3_ADD_SUB:
					begin
						alu_op  = alt7 ? ALU_SUB : ALU_ADD;
						res_sel = RES_ARITH;
						legal   = base7 || alt7;
					end
					`FUNCT3_SLL:
					begin
						alu_op  = ALU_SLL;
						res_sel = RES_SHIFT;
						legal   = base7;
					end
					`FUNCT3_SRL_SRA:
					begin
						alu_op  = alt7 ? ALU_SRA : ALU_SRL;
						res_sel = RES_SHIFT;
						legal   = base7 || alt7;
					end
					`FUNCT3_XOR:
					begin
						alu_op  = ALU_XOR;
						res_sel = RES_LOGIC;
						legal   = base7;
					end
					`FUNCT3_OR:
					begin
						alu_op  = ALU_OR;
						res_sel = RES_LOGIC;
						legal   = base7;
					end
					`FUNCT3_AND:
					begin
						alu_op  = ALU_AND;
						res_sel = RES_LOGIC;
						legal   = base7;
					end
					default:
					begin
						legal = 1'b0;
					end
				endcase
			end

			default:
			begin
				legal = 1'b0;
			end
		endcase

		// no x0 writes, so forwarding never matches x0
		we = legal && (rd != '0);

		// bubble: no reads, no write
		if (!(fetch_i.valid && legal))
		begin
			alu_op   = ALU_NOP;
			res_sel  = RES_NOP;
			rs1_en_o = 1'b0;
			rs2_en_o = 1'b0;
			we       = 1'b0;
		end
	end

	// execute first, then memory, then register file
	function automatic logic [`RV_XLEN-1:0] pick_operand(
		input logic                      en,
		input logic [`RV_REG_ADDR_W-1:0] addr,
		input logic [`RV_XLEN-1:0]       rf_data,
		input logic [`RV_XLEN-1:0]       imm_val
	);
		if (!en)
			return imm_val;
		else if (ex_fwd_i.we && ex_fwd_i.waddr == addr)
			return ex_fwd_i.wdata;
		else if (mem_fwd_i.we && mem_fwd_i.waddr == addr)
			return mem_fwd_i.wdata;
		else
			return rf_data;
	endfunction

	always_comb
	begin
		dec_o.valid   = fetch_i.valid;
		dec_o.illegal = fetch_i.valid && !legal;
		dec_o.alu_op  = alu_op;
		dec_o.res_sel = res_sel;
		dec_o.op1     = pick_operand(rs1_en_o, rs1_addr_o, rs1_data_i, imm);
		dec_o.op2     = pick_operand(rs2_en_o, rs2_addr_o, rs2_data_i, imm);
		dec_o.we      = we;
		dec_o.waddr   = rd;
	end

endmodule

`default_nettype wire

//--- source/rv_execute.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_params.svh"

module rv_execute
	import rv_pkg::*;
(
	input  dec_t dec_i,
	output wb_t  res_o
);

	logic [`RV_XLEN-1:0]       arith_res;
	logic [`RV_XLEN-1:0]       logic_res;
	logic [`RV_XLEN-1:0]       shift_res;
	logic [`RV_REG_ADDR_W-1:0] shamt;

	assign shamt = dec_i.op2[`RV_REG_ADDR_W-1:0];

	assign arith_res = (dec_i.alu_op == ALU_SUB) ? dec_i.op1 - dec_i.op2
	                                              : dec_i.op1 + dec_i.op2;

	always_comb
	begin
		case (dec_i.alu_op)
			ALU_AND: logic_res = dec_i.op1 & dec_i.op2;
			ALU_OR:  logic_res = dec_i.op1 | dec_i.op2;
			ALU_XOR: logic_res = dec_i.op1 ^ dec_i.op2;
			default: logic_res = '0;
		endcase
	end

	always_comb
	begin
		case (dec_i.alu_op)
			ALU_SLL: shift_res = dec_i.op1 << shamt;
			ALU_SRL: shift_res = dec_i.op1 >> shamt;
			// sign fill
			ALU_SRA: shift_res = $signed(dec_i.op1) >>> shamt;
			default: shift_res = '0;
		endcase
	end

	always_comb
	begin
		res_o.valid   = dec_i.valid;
		res_o.illegal = dec_i.illegal;
		res_o.we      = dec_i.we;
		res_o.waddr   = dec_i.waddr;
		case (dec_i.res_sel)
			RES_LOGIC: res_o.wdata = logic_res;
			RES_SHIFT: res_o.wdata = shift_res;
			RES_ARITH: res_o.wdata = arith_res;
			default:   res_o.wdata = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- source/rv_fetch.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_params.svh"

module rv_fetch
	import rv_pkg::*;
(
	input  wire                clk,
	input  wire                rst,
	input  wire [`RV_XLEN-1:0] inst_i,
	output logic [`RV_XLEN-1:0] inst_addr_o,
	output fetch_t             fetch_o
);

	logic [`RV_XLEN-1:0] pc_q;
	// address whose word arrives on inst_i this cycle
	logic [`RV_XLEN-1:0] issued_pc_q;
	logic                issued_q;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			pc_q          <= '0;
			issued_pc_q   <= '0;
			issued_q      <= 1'b0;
			fetch_o.valid <= 1'b0;
			fetch_o.pc    <= '0;
			fetch_o.inst  <= `RV_NOP_INST;
		end
		else
		begin
			pc_q          <= pc_q + `RV_XLEN'd4;
			issued_pc_q   <= pc_q;
			issued_q      <= 1'b1;
			fetch_o.valid <= issued_q;
			fetch_o.pc    <= issued_pc_q;
			fetch_o.inst  <= inst_i;
		end
	end

	assign inst_addr_o = pc_q;

endmodule

`default_nettype wire

//--- source/rv_params.svh
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// datapath widths
`define RV_XLEN         32
`define RV_REG_ADDR_W   5

// addi x0, x0, 0
`define RV_NOP_INST     32'h0000_0013

// major opcodes
`define OP_LUI          7'b0110111
`define OP_OPI          7'b0010011
`define OP_OP           7'b0110011

// funct3, shared by register and immediate forms
`define FUNCT3_ADD_SUB  3'b000
`define FUNCT3_SLL      3'b001
`define FUNCT3_XOR      3'b100
`define FUNCT3_SRL_SRA  3'b101
`define FUNCT3_OR       3'b110
`define FUNCT3_AND      3'b111

// funct7, alternate form selects sub and sra
`define FUNCT7_BASE     7'b0000000
`define FUNCT7_ALT      7'b0100000

`endif

//--- source/rv_pkg.sv
`default_nettype none
`include "rv_params.svh"

package rv_pkg;

	typedef enum logic [3:0] {
		ALU_NOP,
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA
	} alu_op_e;

	typedef enum logic [1:0] {
		RES_NOP,
		RES_LOGIC,
		RES_SHIFT,
		RES_ARITH
	} res_sel_e;

	// fetch to decode
	typedef struct packed {
		logic                      valid;
		logic [`RV_XLEN-1:0]       pc;
		logic [`RV_XLEN-1:0]       inst;
	} fetch_t;

	// decode to execute, operands already resolved
	typedef struct packed {
		logic                      valid;
		logic                      illegal;
		alu_op_e                   alu_op;
		res_sel_e                  res_sel;
		logic [`RV_XLEN-1:0]       op1;
		logic [`RV_XLEN-1:0]       op2;
		logic                      we;
		logic [`RV_REG_ADDR_W-1:0] waddr;
	} dec_t;

	// result on its way to the register file
	typedef struct packed {
		logic                      valid;
		logic                      illegal;
		logic                      we;
		logic [`RV_REG_ADDR_W-1:0] waddr;
		logic [`RV_XLEN-1:0]       wdata;
	} wb_t;

endpackage

`default_nettype wire

//--- source/rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_params.svh"

module rv_regfile
	import rv_pkg::*;
(
	input  wire                       clk,
	input  wire                       rst,
	input  wire [`RV_REG_ADDR_W-1:0]  rs1_addr_i,
	input  wire [`RV_REG_ADDR_W-1:0]  rs2_addr_i,
	input  wire                       rs1_en_i,
	input  wire                       rs2_en_i,
	output logic [`RV_XLEN-1:0]       rs1_data_o,
	output logic [`RV_XLEN-1:0]       rs2_data_o,
	input  wb_t                       wb_i
);

	logic [`RV_XLEN-1:0] regs [32];

	// x0 is never written and keeps its reset zero
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end
		else if (wb_i.we)
		begin
			regs[wb_i.waddr] <= wb_i.wdata;
		end
	end

	function automatic logic [`RV_XLEN-1:0] read_port(
		input logic                      en,
		input logic [`RV_REG_ADDR_W-1:0] addr
	);
		if (!en)
			return '0;
		else if (wb_i.we && wb_i.waddr == addr)
			return wb_i.wdata;
		else
			return regs[addr];
	endfunction

	always_comb
	begin
		rs1_data_o = read_port(rs1_en_i, rs1_addr_i);
		rs2_data_o = read_port(rs2_en_i, rs2_addr_i);
	end

endmodule

`default_nettype wire

//--- source/rv_stage_reg.sv
`timescale 1ns/1ps
`default_nettype none

module rv_stage_reg #(
	parameter type payload_t = logic
) (
	input  wire      clk,
	input  wire      rst,
	input  payload_t d_i,
	output payload_t q_o
);

	// all zeros is an invalid bubble
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			q_o <= '0;
		end
		else
		begin
			q_o <= d_i;
		end
	end

endmodule

`default_nettype wire

//--- verif/rv_core_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_params.svh"

module rv_core_tb;

	localparam int IMEM_WORDS = 512;
	localparam int TIMEOUT    = 1000;
	localparam int N_RANDOM   = 200;

	// expected writeback of one issued instruction
	typedef struct packed {
		int                        idx;
		int                        cyc;
		logic                      illegal;
		logic                      en;
		logic [`RV_REG_ADDR_W-1:0] addr;
		logic [`RV_XLEN-1:0]       data;
	} exp_t;

	logic                      clk;
	logic                      rst;
	logic [`RV_XLEN-1:0]       inst_i;
	logic [`RV_XLEN-1:0]       inst_addr_o;
	logic                      wb_en_o;
	logic [`RV_REG_ADDR_W-1:0] wb_addr_o;
	logic [`RV_XLEN-1:0]       wb_data_o;
	logic                      wb_illegal_o;

	logic [`RV_XLEN-1:0] imem [IMEM_WORDS];
	logic [`RV_XLEN-1:0] model_regs [32];
	int                  prog_len = 0;
	string               test_names [$];
	int                  test_ends [$];

	exp_t                issue_q [$];
	exp_t                exp_wb = '0;
	logic [`RV_XLEN-1:0] exp_pc = '0;
	int                  chk_idx = -1;
	int                  cyc = 0;
	logic                chk_on = 1'b0;
	int                  err_count = 0;
	int                  tests_passed = 0;
	int                  tests_failed = 0;

	rv_core rv_core_inst (
		.clk          (clk),
		.rst          (rst),
		.inst_i       (inst_i),
		.inst_addr_o  (inst_addr_o),
		.wb_en_o      (wb_en_o),
		.wb_addr_o    (wb_addr_o),
		.wb_data_o    (wb_data_o),
		.wb_illegal_o (wb_illegal_o)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [`RV_XLEN-1:0] read_imem(input logic [`RV_XLEN-1:0] addr);
		if (addr[`RV_XLEN-1:2] < IMEM_WORDS)
			return imem[int'(addr[`RV_XLEN-1:2])];
		else
			return `RV_NOP_INST;
	endfunction

	// reference model run in program order at issue time
	function automatic exp_t model_step(input logic [`RV_XLEN-1:0] w);
		exp_t                      e;
		logic [`RV_XLEN-1:0]       a;
		logic [`RV_XLEN-1:0]       b;
		logic [`RV_XLEN-1:0]       imm;
		logic [`RV_XLEN-1:0]       res;
		logic [4:0]                sh;
		logic [`RV_REG_ADDR_W-1:0] rd;
		logic                      ok;
		a   = model_regs[w[19:15]];
		b   = model_regs[w[24:20]];
		imm = {{20{w[31]}}, w[31:20]};
		sh  = w[24:20];
		rd  = w[11:7];
		res = '0;
		ok  = 1'b1;
		case (w[6:0])
			`OP_LUI: res = {w[31:12], 12'h000};
			`OP_OPI:
			case (w[14:12])
				`FUNCT3_ADD_SUB: res = a + imm;
				`FUNCT3_XOR:     res = a ^ imm;
				`FUNCT3_OR:      res = a | imm;
				`FUNCT3_AND:     res = a & imm;
				`FUNCT3_SLL:
				if (w[31:25] == `FUNCT7_BASE)
					res = a << sh;
				else
					ok = 1'b0;
				`FUNCT3_SRL_SRA:
				if (w[31:25] == `FUNCT7_BASE)
					res = a >> sh;
				else if (w[31:25] == `FUNCT7_ALT)
					res = (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
				else
					ok = 1'b0;
				default: ok = 1'b0;
			endcase
			`OP_OP:
			case ({w[31:25], w[14:12]})
				{`FUNCT7_BASE, `FUNCT3_ADD_SUB}: res = a + b;
				{`FUNCT7_ALT, `FUNCT3_ADD_SUB}:  res = a - b;
				{`FUNCT7_BASE, `FUNCT3_AND}:     res = a & b;
				{`FUNCT7_BASE, `FUNCT3_OR}:      res = a | b;
				{`FUNCT7_BASE, `FUNCT3_XOR}:     res = a ^ b;
				{`FUNCT7_BASE, `FUNCT3_SLL}:     res = a << b[4:0];
				{`FUNCT7_BASE, `FUNCT3_SRL_SRA}: res = a >> b[4:0];
				{`FUNCT7_ALT, `FUNCT3_SRL_SRA}:
					res = (a >> b[4:0]) | (a[31] ? ~(32'hffff_ffff >> b[4:0]) : 32'h0);
				default: ok = 1'b0;
			endcase
			default: ok = 1'b0;
		endcase
		e         = '0;
		e.illegal = !ok;
		e.en      = ok && (rd != '0);
		if (e.en)
		begin
			e.addr         = rd;
			e.data         = res;
			model_regs[rd] = res;
		end
		return e;
	endfunction

	// instruction memory, model and expected writeback four edges later
	always @(posedge clk)
	begin : issue_and_expect
		exp_t                ent;
		logic [`RV_XLEN-1:0] word;
		chk_on <= 1'b1;
		word = read_imem(inst_addr_o);
		inst_i <= word;
		if (rst)
		begin
			issue_q.delete();
			exp_wb <= '0;
			exp_pc <= '0;
			cyc = 0;
		end
		else
		begin
			exp_pc  <= exp_pc + 32'd4;
			ent     = model_step(word);
			ent.idx = int'(inst_addr_o[`RV_XLEN-1:2]);
			ent.cyc = cyc;
			issue_q.push_back(ent);
			if (issue_q[0].cyc == cyc - 4)
			begin
				exp_wb  <= issue_q[0];
				chk_idx <= issue_q[0].idx;
				void'(issue_q.pop_front());
			end
			else
				exp_wb <= '0;
			cyc++;
		end
	end

	task automatic report_mismatch(input string name, input logic [`RV_XLEN-1:0] expected,
		input logic [`RV_XLEN-1:0] actual);
		$display("FAIL time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
		err_count++;
	endtask

	a_wb_en: assert property (@(posedge clk) disable iff (!chk_on) wb_en_o == exp_wb.en)
	else
		report_mismatch("wb_en_o", 32'($sampled(exp_wb.en)), 32'($sampled(wb_en_o)));

	a_wb_illegal: assert property (@(posedge clk) disable iff (!chk_on)
		wb_illegal_o == exp_wb.illegal)
	else
		report_mismatch("wb_illegal_o", 32'($sampled(exp_wb.illegal)),
			32'($sampled(wb_illegal_o)));

	a_wb_addr: assert property (@(posedge clk) disable iff (!chk_on)
		exp_wb.en |-> wb_addr_o == exp_wb.addr)
	else
		report_mismatch("wb_addr_o", 32'($sampled(exp_wb.addr)), 32'($sampled(wb_addr_o)));

	a_wb_data: assert property (@(posedge clk) disable iff (!chk_on)
		exp_wb.en |-> wb_data_o == exp_wb.data)
	else
		report_mismatch("wb_data_o", $sampled(exp_wb.data), $sampled(wb_data_o));

	a_pc_reset: assert property (@(posedge clk) disable iff (!chk_on)
		rst |=> inst_addr_o == '0)
	else
		report_mismatch("inst_addr_o", '0, $sampled(inst_addr_o));

	a_pc_step: assert property (@(posedge clk) disable iff (!chk_on)
		!rst |=> inst_addr_o == exp_pc)
	else
		report_mismatch("inst_addr_o", $sampled(exp_pc), $sampled(inst_addr_o));

	task automatic emit_word(input logic [`RV_XLEN-1:0] w);
		imem[prog_len] = w;
		prog_len++;
	endtask

	task automatic emit_imm(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
		input logic [11:0] imm);
		emit_word({imm, rs1, f3, rd, `OP_OPI});
	endtask

	task automatic emit_reg(input logic [6:0] f7, input logic [2:0] f3, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [4:0] rs2);
		emit_word({f7, rs2, rs1, f3, rd, `OP_OP});
	endtask

	task automatic emit_lui(input logic [4:0] rd, input logic [19:0] imm);
		emit_word({imm, rd, `OP_LUI});
	endtask

	task automatic emit_nops(input int n);
		repeat (n)
			emit_word(`RV_NOP_INST);
	endtask

	task automatic close_test(input string name);
		test_names.push_back(name);
		test_ends.push_back(prog_len);
	endtask

	task automatic emit_random(input int n);
		logic [31:0] r;
		logic [31:0] v;
		for (int i = 0; i < n; i++)
		begin
			r = $urandom();
			v = $urandom();
			case (r[3:0])
				4'd0:  emit_lui(r[8:4], v[19:0]);
				4'd1:  emit_imm(`FUNCT3_ADD_SUB, r[8:4], r[13:9], v[11:0]);
				4'd2:  emit_imm(`FUNCT3_XOR, r[8:4], r[13:9], v[11:0]);
				4'd3:  emit_imm(`FUNCT3_OR, r[8:4], r[13:9], v[11:0]);
				4'd4:  emit_imm(`FUNCT3_AND, r[8:4], r[13:9], v[11:0]);
				4'd5:  emit_imm(`FUNCT3_SLL, r[8:4], r[13:9], {`FUNCT7_BASE, r[18:14]});
				4'd6:  emit_imm(`FUNCT3_SRL_SRA, r[8:4], r[13:9], {`FUNCT7_BASE, r[18:14]});
				4'd7:  emit_imm(`FUNCT3_SRL_SRA, r[8:4], r[13:9], {`FUNCT7_ALT, r[18:14]});
				4'd8:  emit_reg(`FUNCT7_BASE, `FUNCT3_ADD_SUB, r[8:4], r[13:9], r[18:14]);
				4'd9:  emit_reg(`FUNCT7_ALT, `FUNCT3_ADD_SUB, r[8:4], r[13:9], r[18:14]);
				4'd10: emit_reg(`FUNCT7_BASE, `FUNCT3_AND, r[8:4], r[13:9], r[18:14]);
				4'd11: emit_reg(`FUNCT7_BASE, `FUNCT3_OR, r[8:4], r[13:9], r[18:14]);
				4'd12: emit_reg(`FUNCT7_BASE, `FUNCT3_XOR, r[8:4], r[13:9], r[18:14]);
				4'd13: emit_reg(`FUNCT7_BASE, `FUNCT3_SLL, r[8:4], r[13:9], r[18:14]);
				4'd14: emit_reg(`FUNCT7_BASE, `FUNCT3_SRL_SRA, r[8:4], r[13:9], r[18:14]);
				default: emit_reg(`FUNCT7_ALT, `FUNCT3_SRL_SRA, r[8:4], r[13:9], r[18:14]);
			endcase
		end
	endtask

	task automatic build_program();
		for (int i = 0; i < IMEM_WORDS; i++)
			imem[i] = `RV_NOP_INST;
		emit_lui(1, 20'h12345);
		emit_imm(`FUNCT3_ADD_SUB, 2, 0, 12'hfff);
		emit_imm(`FUNCT3_ADD_SUB, 3, 0, 12'h7ff);
		emit_imm(`FUNCT3_ADD_SUB, 4, 1, 12'h800);
		emit_lui(12, 20'h80000);
		emit_imm(`FUNCT3_XOR, 5, 1, 12'h0f0);
		emit_imm(`FUNCT3_XOR, 6, 3, 12'hfff);
		emit_imm(`FUNCT3_OR, 7, 1, 12'h555);
		emit_imm(`FUNCT3_AND, 8, 2, 12'hf00);
		emit_imm(`FUNCT3_AND, 9, 1, 12'h0ff);
		emit_imm(`FUNCT3_SLL, 10, 3, {`FUNCT7_BASE, 5'd20});
		emit_imm(`FUNCT3_SRL_SRA, 11, 12, {`FUNCT7_BASE, 5'd4});
		emit_imm(`FUNCT3_SRL_SRA, 13, 12, {`FUNCT7_ALT, 5'd31});
		emit_imm(`FUNCT3_SRL_SRA, 14, 1, {`FUNCT7_ALT, 5'd8});
		close_test("immediate");
		emit_reg(`FUNCT7_BASE, `FUNCT3_ADD_SUB, 15, 1, 3);
		emit_reg(`FUNCT7_ALT, `FUNCT3_ADD_SUB, 16, 3, 1);
		emit_reg(`FUNCT7_BASE, `FUNCT3_AND, 17, 1, 2);
		emit_reg(`FUNCT7_BASE, `FUNCT3_OR, 18, 3, 12);
		emit_reg(`FUNCT7_BASE, `FUNCT3_XOR, 19, 1, 2);
		// 35 shifts by 3
		emit_imm(`FUNCT3_ADD_SUB, 20, 0, 12'd35);
		emit_reg(`FUNCT7_BASE, `FUNCT3_SLL, 21, 1, 20);
		emit_reg(`FUNCT7_BASE, `FUNCT3_SRL_SRA, 22, 12, 20);
		emit_reg(`FUNCT7_ALT, `FUNCT3_SRL_SRA, 23, 12, 20);
		emit_reg(`FUNCT7_ALT, `FUNCT3_SRL_SRA, 24, 1, 20);
		emit_reg(`FUNCT7_ALT, `FUNCT3_SRL_SRA, 25, 12, 2);
		close_test("register");
		emit_imm(`FUNCT3_ADD_SUB, 5, 0, 12'd100);
		emit_imm(`FUNCT3_ADD_SUB, 6, 5, 12'd1);
		emit_reg(`FUNCT7_BASE, `FUNCT3_ADD_SUB, 7, 3, 6);
		emit_reg(`FUNCT7_BASE, `FUNCT3_ADD_SUB, 8, 7, 7);
		// younger producer must win
		emit_imm(`FUNCT3_ADD_SUB, 9, 0, 12'd1);
		emit_imm(`FUNCT3_ADD_SUB, 9, 0, 12'd2);
		emit_reg(`FUNCT7_BASE, `FUNCT3_ADD_SUB, 10, 9, 9);
		emit_imm(`FUNCT3_ADD_SUB, 11, 0, 12'd7);
		emit_nops(1);
		emit_reg(`FUNCT7_BASE, `FUNCT3_ADD_SUB, 26, 11, 1);
		emit_imm(`FUNCT3_ADD_SUB, 11, 0, 12'd9);
		emit_nops(1);
		emit_reg(`FUNCT7_ALT, `FUNCT3_ADD_SUB, 27, 1, 11);
		emit_imm(`FUNCT3_ADD_SUB, 13, 0, 12'd13);
		emit_nops(2);
		emit_reg(`FUNCT7_BASE, `FUNCT3_ADD_SUB, 28, 13, 13);
		emit_imm(`FUNCT3_ADD_SUB, 13, 0, 12'hffb);
		emit_nops(2);
		emit_reg(`FUNCT7_ALT, `FUNCT3_ADD_SUB, 29, 1, 13);
		emit_imm(`FUNCT3_ADD_SUB, 30, 0, 12'd17);
		emit_nops(3);
		emit_reg(`FUNCT7_BASE, `FUNCT3_OR, 31, 30, 1);
		emit_reg(`FUNCT7_BASE, `FUNCT3_AND, 31, 2, 30);
		close_test("forwarding");
		emit_imm(`FUNCT3_ADD_SUB, 0, 0, 12'd55);
		emit_reg(`FUNCT7_BASE, `FUNCT3_ADD_SUB, 0, 1, 1);
		emit_lui(0, 20'habcde);
		emit_reg(`FUNCT7_BASE, `FUNCT3_ADD_SUB, 22, 0, 0);
		emit_imm(`FUNCT3_OR, 23, 0, 12'h000);
		// lw, mul, bad shift funct7, xor alt, slti, slt, all ones
		emit_word(32'h0000_2083);
		emit_reg(7'b0000001, `FUNCT3_ADD_SUB, 1, 1, 2);
		emit_imm(`FUNCT3_SLL, 2, 1, {`FUNCT7_ALT, 5'd3});
		emit_imm(`FUNCT3_SRL_SRA, 3, 1, {7'b0010000, 5'd3});
		emit_reg(`FUNCT7_ALT, `FUNCT3_XOR, 5, 1, 2);
		emit_imm(3'b010, 6, 1, 12'd5);
		emit_reg(`FUNCT7_BASE, 3'b010, 7, 1, 2);
		emit_word(32'hffff_ffff);
		emit_reg(`FUNCT7_BASE, `FUNCT3_OR, 24, 1, 2);
		emit_reg(`FUNCT7_BASE, `FUNCT3_OR, 25, 3, 5);
		emit_reg(`FUNCT7_BASE, `FUNCT3_OR, 26, 6, 7);
		close_test("x0_illegal");
		emit_random(N_RANDOM);
		close_test("random");
	endtask

	task automatic wait_for_check(input int last, output bit timed_out);
		int waited;
		waited = 0;
		while (chk_idx < last && waited < TIMEOUT)
		begin
			@(posedge clk);
			waited++;
		end
		timed_out = (chk_idx < last);
	endtask

	task automatic report_test(input string name, input int errs);
		if (errs == 0)
		begin
			$display("test %s: passed", name);
			tests_passed++;
		end
		else
		begin
			$display("test %s: failed with %0d errors", name, errs);
			tests_failed++;
		end
	endtask

	initial
	begin
		int    mark;
		bit    timed_out;
		string stalled;
		rst    = 1'b1;
		inst_i = `RV_NOP_INST;
		void'($urandom(66));
		for (int i = 0; i < 32; i++)
			model_regs[i] = '0;
		build_program();
		repeat (10) @(posedge clk);
		rst <= 1'b0;

		// reset window ends when the first result is due
		mark = err_count;
		wait_for_check(0, timed_out);
		if (timed_out)
			stalled = "reset";
		else
			report_test("reset", err_count - mark);

		for (int t = 0; t < test_names.size() && !timed_out; t++)
		begin
			mark = err_count;
			wait_for_check(test_ends[t] - 1, timed_out);
			if (timed_out)
				stalled = test_names[t];
			else
			begin
				@(posedge clk);
				report_test(test_names[t], err_count - mark);
			end
		end

		if (timed_out)
			$display("timeout: results of test %s never reached writeback", stalled);
		$display("summary: %0d tests passed, %0d tests failed, %0d check errors",
			tests_passed, tests_failed, err_count);
		if (!timed_out && tests_failed == 0 && err_count == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire
